/* exe_consts.svh */
`ifndef EXE_CONSTS_SVH
`define EXE_CONSTS_SVH

`define EXE_XLEN        64
`define EXE_OP_W        5
`define EXE_SRC_W       2

// Operation codes. Values above 20 are unused and give a zero result
`define EXE_OP_NOP      5'd0
`define EXE_OP_SLL      5'd1
`define EXE_OP_SRL      5'd2
`define EXE_OP_SRA      5'd3
`define EXE_OP_ADD      5'd4
`define EXE_OP_SUB      5'd5
`define EXE_OP_XOR      5'd6
`define EXE_OP_OR       5'd7
`define EXE_OP_AND      5'd8
`define EXE_OP_SLT      5'd9
`define EXE_OP_SLTU     5'd10
`define EXE_OP_SLLW     5'd11
`define EXE_OP_SRLW     5'd12
`define EXE_OP_SRAW     5'd13
`define EXE_OP_ADDW     5'd14
`define EXE_OP_SUBW     5'd15
`define EXE_OP_MUL      5'd16
`define EXE_OP_MULH     5'd17
`define EXE_OP_MULHSU   5'd18
`define EXE_OP_MULHU    5'd19
`define EXE_OP_MULW     5'd20

`define EXE_SRC_NONE    2'd0
`define EXE_SRC_R_R     2'd1
`define EXE_SRC_R_I     2'd2
`define EXE_SRC_PC_I    2'd3

`define EXE_MUL_CYCLES  64  // One multiplier bit per cycle

`endif

/* exe_pkg.sv */
`default_nettype none

`include "exe_consts.svh"

package exe_pkg;

    typedef logic [`EXE_XLEN-1:0]  xlen_t;
    typedef logic [`EXE_OP_W-1:0]  exe_op_t;
    typedef logic [`EXE_SRC_W-1:0] exe_src_t;
    typedef logic [1:0]            mul_sign_t;  // Bit 1 marks operand 1 as signed

    typedef enum logic [1:0] {
        EXE_IDLE,
        EXE_MUL_BUSY,
        EXE_DONE
    } exe_state_t;

endpackage

`default_nettype wire

/* exe_operand_if.sv */
`timescale 1ns/1ps
`default_nettype none

// Selected operands of the instruction currently held by the stage
interface exe_operand_if;

    logic               valid;
    exe_pkg::exe_op_t   op;
    exe_pkg::xlen_t     src1;
    exe_pkg::xlen_t     src2;

    modport issue (
        output valid, op, src1, src2
    );

    modport consume (
        input valid, op, src1, src2
    );

endinterface

`default_nettype wire

/* exe_issue.sv */
`timescale 1ns/1ps
`default_nettype none

`include "exe_consts.svh"

module exe_issue (
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     in_valid,
    input  wire exe_pkg::exe_op_t   op,
    input  wire exe_pkg::exe_src_t  src_sel,
    input  wire exe_pkg::xlen_t     rs1_data,
    input  wire exe_pkg::xlen_t     rs2_data,
    input  wire exe_pkg::xlen_t     imm,
    input  wire exe_pkg::xlen_t     pc,
    input  wire                     out_ready,
    input  wire                     mul_done,
    exe_operand_if.issue            opnd,
    output logic                    mul_start,
    output exe_pkg::mul_sign_t      mul_sign,
    output logic                    out_valid,
    output logic                    in_ready
);

    exe_pkg::exe_state_t state;
    exe_pkg::exe_state_t state_next;
    logic                is_mul;

    assign is_mul    = (op >= `EXE_OP_MUL) && (op <= `EXE_OP_MULW);
    assign opnd.valid = in_valid;
    assign opnd.op    = op;

    always_comb begin
        opnd.src1 = '0;
        opnd.src2 = '0;
        if (in_valid) begin
            case (src_sel)
                `EXE_SRC_R_R: begin
                    opnd.src1 = rs1_data;
                    opnd.src2 = rs2_data;
                end
                `EXE_SRC_R_I: begin
                    opnd.src1 = rs1_data;
                    opnd.src2 = imm;
                end
                `EXE_SRC_PC_I: begin
                    opnd.src1 = pc;
                    opnd.src2 = imm;
                end
                default: begin
                    opnd.src1 = '0;
                    opnd.src2 = '0;
                end
            endcase
        end
    end

    always_comb begin
        case (op)
            `EXE_OP_MULHSU: mul_sign = 2'b10;
            `EXE_OP_MULHU:  mul_sign = 2'b00;
            default:        mul_sign = 2'b11;  // mul, mulh and mulw are signed on both sides
        endcase
    end

    always_comb begin
        state_next = state;
        mul_start  = 1'b0;
        out_valid  = 1'b0;
        in_ready   = 1'b0;
        case (state)
            exe_pkg::EXE_IDLE: begin
                if (!in_valid) begin
                    in_ready = 1'b1;
                end else if (is_mul) begin
                    mul_start  = 1'b1;
                    state_next = exe_pkg::EXE_MUL_BUSY;
                end else begin
                    // ALU results pass straight through to the next stage
                    out_valid = 1'b1;
                    in_ready  = out_ready;
                end
            end
            exe_pkg::EXE_MUL_BUSY: begin
                if (mul_done) begin
                    state_next = exe_pkg::EXE_DONE;
                end
            end
            exe_pkg::EXE_DONE: begin
                out_valid = 1'b1;
                in_ready  = out_ready;
                if (out_ready) begin
                    state_next = exe_pkg::EXE_IDLE;
                end
            end
            default: state_next = exe_pkg::EXE_IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= exe_pkg::EXE_IDLE;
        end else begin
            state <= state_next;
        end
    end

    a_start_from_idle: assert property (@(posedge clk) disable iff (rst)
        mul_start |-> (state == exe_pkg::EXE_IDLE) ##1 (state == exe_pkg::EXE_MUL_BUSY));

    // A finished product waits until the next stage takes it
    a_hold_result: assert property (@(posedge clk) disable iff (rst)
        (state == exe_pkg::EXE_DONE && !out_ready) |=> (state == exe_pkg::EXE_DONE) && out_valid);

endmodule

`default_nettype wire

/* exe_mul.sv */
`timescale 1ns/1ps
`default_nettype none

`include "exe_consts.svh"

module exe_mul (
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     start,
    input  wire exe_pkg::mul_sign_t sign,
    exe_operand_if.consume          opnd,
    output logic                    done,
    output exe_pkg::xlen_t          hi,
    output exe_pkg::xlen_t          lo
);

    localparam int CNT_W = $clog2(`EXE_MUL_CYCLES);

    logic                   busy;
    logic [CNT_W-1:0]       cnt;
    logic                   neg;
    logic                   a_neg;
    logic                   b_neg;
    exe_pkg::xlen_t         mcand;
    logic [2*`EXE_XLEN-1:0] prod;
    logic [`EXE_XLEN:0]     partial;
    logic [2*`EXE_XLEN-1:0] prod_next;

    assign a_neg = sign[1] & opnd.src1[`EXE_XLEN-1];
    assign b_neg = sign[0] & opnd.src2[`EXE_XLEN-1];

    // The low half of prod starts as the multiplier and is shifted out one bit per step
    assign partial   = {1'b0, prod[2*`EXE_XLEN-1:`EXE_XLEN]} + (prod[0] ? {1'b0, mcand} : '0);
    assign prod_next = {partial, prod[`EXE_XLEN-1:1]};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy <= 1'b0;
            cnt  <= '0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                busy <= 1'b1;
                cnt  <= CNT_W'(`EXE_MUL_CYCLES - 1);
            end else if (busy) begin
                cnt <= cnt - 1'b1;
                if (cnt == '0) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            mcand <= a_neg ? -opnd.src1 : opnd.src1;  // Operands are latched as magnitudes
            prod  <= {{`EXE_XLEN{1'b0}}, (b_neg ? -opnd.src2 : opnd.src2)};
            neg   <= a_neg ^ b_neg;
        end else if (busy) begin
            prod <= prod_next;
            if (cnt == '0) begin
                {hi, lo} <= neg ? -prod_next : prod_next;
            end
        end
    end

    a_no_restart: assert property (@(posedge clk) disable iff (rst)
        start |-> !busy);

    // Done is set on the edge EXE_MUL_CYCLES cycles after start and is seen one edge later
    a_latency: assert property (@(posedge clk) disable iff (rst)
        start |-> ##(`EXE_MUL_CYCLES + 1) done);

endmodule

`default_nettype wire

/* exe_alu.sv */
`timescale 1ns/1ps
`default_nettype none

`include "exe_consts.svh"

module exe_alu (
    exe_operand_if.consume      opnd,
    input  wire exe_pkg::xlen_t mul_hi,
    input  wire exe_pkg::xlen_t mul_lo,
    output exe_pkg::xlen_t      result
);

    function automatic exe_pkg::xlen_t sext_w(input logic [31:0] w);
        return {{(`EXE_XLEN-32){w[31]}}, w};
    endfunction

    exe_pkg::xlen_t a;
    exe_pkg::xlen_t b;
    exe_pkg::xlen_t sum;
    exe_pkg::xlen_t diff;
    logic [5:0]     sh;
    logic [4:0]     shw;

    assign a    = opnd.src1;
    assign b    = opnd.src2;
    assign sum  = a + b;
    assign diff = a - b;
    assign sh   = b[5:0];
    assign shw  = b[4:0];  // W shifts only look at five bits

    always_comb begin
        result = '0;
        if (opnd.valid) begin
            case (opnd.op)
                `EXE_OP_SLL:    result = a << sh;
                `EXE_OP_SRL:    result = a >> sh;
                `EXE_OP_SRA:    result = $signed(a) >>> sh;
                `EXE_OP_ADD:    result = sum;
                `EXE_OP_SUB:    result = diff;
                `EXE_OP_XOR:    result = a ^ b;
                `EXE_OP_OR:     result = a | b;
                `EXE_OP_AND:    result = a & b;
                `EXE_OP_SLT:    result = {{(`EXE_XLEN-1){1'b0}}, $signed(a) < $signed(b)};
                `EXE_OP_SLTU:   result = {{(`EXE_XLEN-1){1'b0}}, a < b};

                // Word forms work on the low half and sign-extend bit 31
                `EXE_OP_SLLW:   result = sext_w(a[31:0] << shw);
                `EXE_OP_SRLW:   result = sext_w(a[31:0] >> shw);
                `EXE_OP_SRAW:   result = sext_w($signed(a[31:0]) >>> shw);
                `EXE_OP_ADDW:   result = sext_w(sum[31:0]);
                `EXE_OP_SUBW:   result = sext_w(diff[31:0]);

                `EXE_OP_MUL:    result = mul_lo;
                `EXE_OP_MULH:   result = mul_hi;
                `EXE_OP_MULHSU: result = mul_hi;
                `EXE_OP_MULHU:  result = mul_hi;
                `EXE_OP_MULW:   result = sext_w(mul_lo[31:0]);
                default:        result = '0;  // NOP and unused codes
            endcase
        end
    end

endmodule

`default_nettype wire

/* exe_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module exe_stage (
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     in_valid,
    input  wire exe_pkg::exe_op_t   op,
    input  wire exe_pkg::exe_src_t  src_sel,
    input  wire exe_pkg::xlen_t     rs1_data,
    input  wire exe_pkg::xlen_t     rs2_data,
    input  wire exe_pkg::xlen_t     imm,
    input  wire exe_pkg::xlen_t     pc,
    input  wire                     out_ready,
    output exe_pkg::xlen_t          out_data,
    output logic                    out_valid,
    output logic                    in_ready
);

    logic               mul_start;
    exe_pkg::mul_sign_t mul_sign;
    logic               mul_done;
    exe_pkg::xlen_t     mul_hi;
    exe_pkg::xlen_t     mul_lo;

    exe_operand_if opnd_if ();

    exe_issue u_issue (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .op        (op),
        .src_sel   (src_sel),
        .rs1_data  (rs1_data),
        .rs2_data  (rs2_data),
        .imm       (imm),
        .pc        (pc),
        .out_ready (out_ready),
        .mul_done  (mul_done),
        .opnd      (opnd_if.issue),
        .mul_start (mul_start),
        .mul_sign  (mul_sign),
        .out_valid (out_valid),
        .in_ready  (in_ready)
    );

    exe_mul u_mul (
        .clk   (clk),
        .rst   (rst),
        .start (mul_start),
        .sign  (mul_sign),
        .opnd  (opnd_if.consume),
        .done  (mul_done),
        .hi    (mul_hi),
        .lo    (mul_lo)
    );

    exe_alu u_alu (
        .opnd   (opnd_if.consume),
        .mul_hi (mul_hi),
        .mul_lo (mul_lo),
        .result (out_data)
    );

endmodule

`default_nettype wire

/* tb_exe_stage.sv */
`timescale 1ns/1ps
`default_nettype none

`include "exe_consts.svh"

module tb_exe_stage;

    localparam int WAIT_LIMIT = 4 * `EXE_MUL_CYCLES + 100;

    logic               clk;
    logic               rst;
    logic               in_valid;
    exe_pkg::exe_op_t   op;
    exe_pkg::exe_src_t  src_sel;
    exe_pkg::xlen_t     rs1_data;
    exe_pkg::xlen_t     rs2_data;
    exe_pkg::xlen_t     imm;
    exe_pkg::xlen_t     pc;
    logic               out_ready;
    exe_pkg::xlen_t     out_data;
    logic               out_valid;
    logic               in_ready;
    logic               bp_on;
    exe_pkg::xlen_t     exp_q[$];

    exe_stage dut0 (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .op        (op),
        .src_sel   (src_sel),
        .rs1_data  (rs1_data),
        .rs2_data  (rs2_data),
        .imm       (imm),
        .pc        (pc),
        .out_ready (out_ready),
        .out_data  (out_data),
        .out_valid (out_valid),
        .in_ready  (in_ready)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] expected);
        if (got !== expected) begin
            $display("Error: %s is %h, expected %h", name, got, expected);
            $display("ERRORS FOUND");
            $fatal(1);
        end
    endtask

    function automatic exe_pkg::xlen_t random_word();
        return {$urandom(), $urandom()};
    endfunction

    function automatic exe_pkg::xlen_t exe_ref(input exe_pkg::exe_op_t f_op,
                                              input exe_pkg::exe_src_t f_src,
                                              input exe_pkg::xlen_t rs1, input exe_pkg::xlen_t rs2,
                                              input exe_pkg::xlen_t f_imm, input exe_pkg::xlen_t f_pc);
        exe_pkg::xlen_t x;
        exe_pkg::xlen_t y;
        logic [127:0]   prod;
        logic [31:0]    w;
        x = (f_src == `EXE_SRC_PC_I) ? f_pc : rs1;
        y = (f_src == `EXE_SRC_R_R) ? rs2 : f_imm;
        if (f_src == `EXE_SRC_NONE) begin
            x = '0;
            y = '0;
        end
        // Each operand is widened to 128 bits by its own signedness
        case (f_op)
            `EXE_OP_MULHU:  prod = {64'd0, x} * {64'd0, y};
            `EXE_OP_MULHSU: prod = {{64{x[63]}}, x} * {64'd0, y};
            default:        prod = {{64{x[63]}}, x} * {{64{y[63]}}, y};
        endcase
        case (f_op)
            `EXE_OP_SLLW: w = x[31:0] << y[4:0];
            `EXE_OP_SRLW: w = x[31:0] >> y[4:0];
            `EXE_OP_SRAW: w = $signed(x[31:0]) >>> y[4:0];
            `EXE_OP_ADDW: w = x[31:0] + y[31:0];
            `EXE_OP_SUBW: w = x[31:0] - y[31:0];
            default:      w = prod[31:0];
        endcase
        case (f_op)
            `EXE_OP_SLL:  return x << y[5:0];
            `EXE_OP_SRL:  return x >> y[5:0];
            `EXE_OP_SRA:  return $signed(x) >>> y[5:0];
            `EXE_OP_ADD:  return x + y;
            `EXE_OP_SUB:  return x - y;
            `EXE_OP_XOR:  return x ^ y;
            `EXE_OP_OR:   return x | y;
            `EXE_OP_AND:  return x & y;
            `EXE_OP_SLT:  return ($signed(x) < $signed(y)) ? 64'd1 : 64'd0;
            `EXE_OP_SLTU: return (x < y) ? 64'd1 : 64'd0;
            `EXE_OP_SLLW, `EXE_OP_SRLW, `EXE_OP_SRAW, `EXE_OP_ADDW, `EXE_OP_SUBW,
            `EXE_OP_MULW: return {{32{w[31]}}, w};
            `EXE_OP_MUL:  return prod[63:0];
            `EXE_OP_MULH, `EXE_OP_MULHSU, `EXE_OP_MULHU: return prod[127:64];
            default:      return '0;
        endcase
    endfunction

    // Called 1 ns after a rising edge and returns at the same point after the transfer
    task automatic send_instr(input exe_pkg::exe_op_t s_op, input exe_pkg::exe_src_t s_src,
                              input exe_pkg::xlen_t s_rs1, input exe_pkg::xlen_t s_rs2,
                              input exe_pkg::xlen_t s_imm, input exe_pkg::xlen_t s_pc);
        int waited;
        exp_q.push_back(exe_ref(s_op, s_src, s_rs1, s_rs2, s_imm, s_pc));
        in_valid = 1'b1;
        op       = s_op;
        src_sel  = s_src;
        rs1_data = s_rs1;
        rs2_data = s_rs2;
        imm      = s_imm;
        pc       = s_pc;
        waited   = 0;
        do begin
            @(negedge clk);
            // A held instruction leaves only together with its result
            check_value("in_ready", 64'(in_ready), 64'(out_valid & out_ready));
            waited++;
            if (waited > WAIT_LIMIT) begin
                abort_run("Timeout: in_ready never went high for a held instruction");
            end
        end while (!in_ready);
        @(posedge clk);
        #1;
        in_valid = 1'b0;
    endtask

    task automatic send_random(input exe_pkg::exe_op_t s_op);
        send_instr(s_op, exe_pkg::exe_src_t'($urandom % 4), random_word(), random_word(),
                   random_word(), random_word());
    endtask

    initial begin
        forever begin
            @(posedge clk);
            #1;
            out_ready = bp_on ? ($urandom % 3 != 0) : 1'b1;
        end
    end

    initial begin : compare
        logic           held;
        exe_pkg::xlen_t held_data;
        held      = 1'b0;
        held_data = '0;
        forever begin
            @(negedge clk);
            if (!rst) begin
                if (held) begin  // A stalled result must stay put
                    check_value("out_valid", 64'(out_valid), 64'd1);
                    check_value("out_data", out_data, held_data);
                end
                if (out_valid && out_ready) begin
                    if (exp_q.size() == 0) begin
                        abort_run("A result came out with no instruction outstanding");
                    end
                    check_value("out_data", out_data, exp_q.pop_front());
                end
                held      = out_valid && !out_ready;
                held_data = out_data;
            end
        end
    end

    initial begin
        exe_pkg::xlen_t corner [4];
        int             waited;
        void'($urandom(32'h08f62766));
        rst       = 1'b1;
        in_valid  = 1'b0;
        op        = '0;
        src_sel   = '0;
        rs1_data  = '0;
        rs2_data  = '0;
        imm       = '0;
        pc        = '0;
        out_ready = 1'b1;
        bp_on     = 1'b0;
        corner[0] = '0;
        corner[1] = '1;
        corner[2] = 64'h8000_0000_0000_0000;
        corner[3] = '0;
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;

        @(negedge clk);
        check_value("out_valid", 64'(out_valid), 64'd0);
        check_value("in_ready", 64'(in_ready), 64'd1);
        @(posedge clk);
        #1;

        for (int o = 0; o <= 10; o++) begin
            for (int s = 0; s < 4; s++) begin
                repeat (3) send_instr(exe_pkg::exe_op_t'(o), exe_pkg::exe_src_t'(s),
                                      random_word(), random_word(), random_word(), random_word());
            end
        end
        for (int o = `EXE_OP_SLL; o <= `EXE_OP_SRA; o++) begin
            send_instr(exe_pkg::exe_op_t'(o), `EXE_SRC_R_R, random_word(), 64'd0, '0, '0);
            send_instr(exe_pkg::exe_op_t'(o), `EXE_SRC_R_R, corner[2], 64'd63, '0, '0);
            send_instr(exe_pkg::exe_op_t'(o), `EXE_SRC_R_I, corner[1], '0, 64'hffff_ffc0, '0);
        end
        for (int o = `EXE_OP_SLT; o <= `EXE_OP_SLTU; o++) begin
            send_instr(exe_pkg::exe_op_t'(o), `EXE_SRC_R_R, corner[1], 64'd1, '0, '0);
            send_instr(exe_pkg::exe_op_t'(o), `EXE_SRC_R_R, 64'd1, corner[1], '0, '0);
            send_instr(exe_pkg::exe_op_t'(o), `EXE_SRC_R_I, corner[2], '0, ~corner[2], '0);
        end
        send_instr(5'd27, `EXE_SRC_R_R, random_word(), random_word(), '0, '0);  // Unused code

        for (int o = `EXE_OP_SLLW; o <= `EXE_OP_SUBW; o++) begin
            repeat (8) send_random(exe_pkg::exe_op_t'(o));
        end
        send_instr(`EXE_OP_ADDW, `EXE_SRC_R_I, 64'h7fff_ffff, '0, 64'd1, '0);
        send_instr(`EXE_OP_SUBW, `EXE_SRC_R_R, 64'd0, 64'd1, '0, '0);
        send_instr(`EXE_OP_SLLW, `EXE_SRC_R_R, 64'd1, 64'd31, '0, '0);
        send_instr(`EXE_OP_SRAW, `EXE_SRC_R_R, 64'h8000_0000, 64'd4, '0, '0);
        send_instr(`EXE_OP_SRLW, `EXE_SRC_R_R, 64'h1_8000_0000, 64'd32, '0, '0);

        for (int o = `EXE_OP_MUL; o <= `EXE_OP_MULW; o++) begin
            for (int i = 0; i < 4; i++) begin
                for (int j = 0; j < 4; j++) begin
                    corner[3] = random_word();
                    send_instr(exe_pkg::exe_op_t'(o), `EXE_SRC_R_R, corner[i], corner[j], '0, '0);
                end
            end
            send_random(exe_pkg::exe_op_t'(o));
        end

        bp_on = 1'b1;
        repeat (80) send_random(exe_pkg::exe_op_t'($urandom % 21));

        waited = 0;
        while (exp_q.size() != 0 && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (exp_q.size() == 0) begin
            $display("NO ERRORS");
            $finish;
        end else begin
            $display("%0d results never came out of the stage", exp_q.size());
            $display("ERRORS FOUND");
            $fatal(1);
        end
    end

endmodule

`default_nettype wire

/* exe_stage.f */
+incdir+.
exe_pkg.sv
exe_operand_if.sv
exe_issue.sv
exe_mul.sv
exe_alu.sv
exe_stage.sv
tb_exe_stage.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps -Wno-fatal
TOP       = tb_exe_stage
FLIST     = exe_stage.f
OBJ_DIR   = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf $(OBJ_DIR)
